//--- include/disp_cfg.svh
// display settings; the register reset values must fit the field widths in disp_pkg
`ifndef DISP_CFG_SVH
`define DISP_CFG_SVH

// binary input width and digit counts
`define DISP_BIN_W 20
`define DISP_DIGITS 6
// seven converter digits hold up to 1,048,575
`define DISP_CONV_DIGITS 7

// receive buffer depth, also the sender's initial credits
`define DISP_CREDITS 2

// register map
`define DISP_ADDR_CTRL 2'd0
`define DISP_ADDR_DP 2'd1
`define DISP_ADDR_DIV 2'd2

// register reset values
`define DISP_ENABLE_RST 1'b1
`define DISP_BLANK_LZ_RST 1'b0
`define DISP_DP_NONE 3'd7
`define DISP_SCAN_DIV_RST 16'd999

`endif

//--- verilog/disp_pkg.sv
// shared display types; widths follow disp_cfg.svh, seg and dig_sel are active low
`default_nettype none

`include "disp_cfg.svh"

package disp_pkg;

    // unsigned binary value from the producer
    typedef logic [`DISP_BIN_W-1:0] bin_value_t;

    // one BCD digit
    typedef logic [3:0] bcd_digit_t;

    // displayed digits, digit 0 in the low nibble
    typedef logic [4*`DISP_DIGITS-1:0] bcd_word_t;

    // bit 0 = a .. bit 6 = g, bit 7 = dp
    typedef logic [7:0] seg_t;

    // one-hot digit enable, low = digit on
    typedef logic [`DISP_DIGITS-1:0] dig_sel_t;

    // register fields
    typedef logic [15:0] scan_div_t;
    typedef logic [2:0] dp_pos_t;
    typedef logic [1:0] cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // converter sequencing
    typedef enum logic [2:0] {
        CONV_IDLE,
        CONV_LOAD,
        CONV_ADJUST,
        CONV_SHIFT,
        CONV_DONE
    } conv_state_t;

endpackage

`default_nettype wire

//--- verilog/bin_to_bcd_conv.sv
// one value converts at a time, 42 cycles pop to bcd_valid; the sender must respect credits
`timescale 1ns/10ps
`default_nettype none

`include "disp_cfg.svh"

module bin_to_bcd_conv
    import disp_pkg::*;
(
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         value_valid,
    input  wire  bin_value_t value,
    output logic        credit_return,
    output logic        bcd_valid,
    output bcd_word_t   bcd_data,
    output logic        ovf
);

    // digit fields sit above the binary field
    localparam int SR_W  = 4*`DISP_CONV_DIGITS + `DISP_BIN_W;
    localparam int PTR_W = ($clog2(`DISP_CREDITS) > 0) ? $clog2(`DISP_CREDITS) : 1;
    localparam int CNT_W = $clog2(`DISP_CREDITS + 1);
    localparam int BIT_W = $clog2(`DISP_BIN_W);

    bin_value_t        fifo_mem [`DISP_CREDITS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fifo_cnt;
    logic              fifo_pop;
    conv_state_t       state;
    conv_state_t       state_nxt;
    logic [SR_W-1:0]   shift_reg;
    logic [BIT_W-1:0]  bit_cnt;
    bcd_digit_t        top_digit;

    //**************************************************************************
    // receive buffer
    //**************************************************************************

    // pop and credit share the load cycle
    assign fifo_pop      = (state == CONV_LOAD);
    assign credit_return = fifo_pop;

    always_ff @(posedge sys_clk) begin
        if (value_valid)
            fifo_mem[wr_ptr] <= value;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (value_valid)
                wr_ptr <= (wr_ptr == PTR_W'(`DISP_CREDITS-1)) ? '0 : wr_ptr + 1'b1;
            if (fifo_pop)
                rd_ptr <= (rd_ptr == PTR_W'(`DISP_CREDITS-1)) ? '0 : rd_ptr + 1'b1;
            // occupancy, credits keep it within depth
            case ({value_valid, fifo_pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    //**************************************************************************
    // sequencing FSM
    //**************************************************************************

    always_comb begin
        state_nxt = state;
        case (state)
            CONV_IDLE:   if (fifo_cnt != '0) state_nxt = CONV_LOAD;
            CONV_LOAD:   state_nxt = CONV_ADJUST;
            CONV_ADJUST: state_nxt = CONV_SHIFT;
            // last shift after DISP_BIN_W passes
            CONV_SHIFT:  state_nxt = (bit_cnt == BIT_W'(`DISP_BIN_W-1)) ? CONV_DONE
                                                                        : CONV_ADJUST;
            // next buffered value goes straight in
            CONV_DONE:   state_nxt = (fifo_cnt != '0) ? CONV_LOAD : CONV_IDLE;
            default:     state_nxt = CONV_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state   <= CONV_IDLE;
            bit_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == CONV_LOAD)
                bit_cnt <= '0;
            else if (state == CONV_SHIFT)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    //**************************************************************************
    // shift and add 3
    //**************************************************************************

    always_ff @(posedge sys_clk) begin
        case (state)
            CONV_LOAD: shift_reg <= {{(4*`DISP_CONV_DIGITS){1'b0}}, fifo_mem[rd_ptr]};
            CONV_ADJUST: begin
                // every digit above 4 gets 3 before the shift
                for (int i = 0; i < `DISP_CONV_DIGITS; i++) begin
                    if (shift_reg[`DISP_BIN_W + 4*i +: 4] > 4'd4)
                        shift_reg[`DISP_BIN_W + 4*i +: 4] <=
                            shift_reg[`DISP_BIN_W + 4*i +: 4] + 4'd3;
                end
            end
            CONV_SHIFT: shift_reg <= shift_reg << 1;
            default:    shift_reg <= shift_reg;
        endcase
    end

    // highest converter digit, non-zero means out of display range
    assign top_digit = shift_reg[SR_W-1 -: 4];

    // result held until the next conversion ends
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bcd_valid <= 1'b0;
            bcd_data  <= '0;
            ovf       <= 1'b0;
        end else begin
            bcd_valid <= (state == CONV_DONE);
            if (state == CONV_DONE) begin
                bcd_data <= shift_reg[`DISP_BIN_W +: 4*`DISP_DIGITS];
                ovf      <= (top_digit != 4'd0);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/disp_cfg_regs.sv
// single-cycle write, combinational read; oversized write data is truncated per field
`timescale 1ns/10ps
`default_nettype none

`include "disp_cfg.svh"

module disp_cfg_regs
    import disp_pkg::*;
(
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         cfg_wr,
    input  wire  cfg_addr_t cfg_addr,
    input  wire  cfg_data_t cfg_wdata,
    output cfg_data_t   cfg_rdata,
    output logic        enable,
    output logic        blank_lz,
    output dp_pos_t     dp_pos,
    output scan_div_t   scan_div
);

    //**************************************************************************
    // register write
    //**************************************************************************

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            enable   <= `DISP_ENABLE_RST;
            blank_lz <= `DISP_BLANK_LZ_RST;
            dp_pos   <= `DISP_DP_NONE;
            scan_div <= `DISP_SCAN_DIV_RST;
        end else if (cfg_wr) begin
            case (cfg_addr)
                // ctrl, bit 0 enable, bit 1 blanking
                `DISP_ADDR_CTRL: begin
                    enable   <= cfg_wdata[0];
                    blank_lz <= cfg_wdata[1];
                end
                `DISP_ADDR_DP:  dp_pos   <= dp_pos_t'(cfg_wdata);
                `DISP_ADDR_DIV: scan_div <= scan_div_t'(cfg_wdata);
                // address 3 has nothing behind it
                default: ;
            endcase
        end
    end

    //**************************************************************************
    // read-back
    //**************************************************************************

    // zero padded above each field
    always_comb begin
        case (cfg_addr)
            `DISP_ADDR_CTRL: cfg_rdata = cfg_data_t'({blank_lz, enable});
            `DISP_ADDR_DP:   cfg_rdata = cfg_data_t'(dp_pos);
            `DISP_ADDR_DIV:  cfg_rdata = cfg_data_t'(scan_div);
            default:         cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/seg_scan.sv
// common-anode, active-low seg and dig_sel; outputs move only on a scan step
`timescale 1ns/10ps
`default_nettype none

`include "disp_cfg.svh"

module seg_scan
    import disp_pkg::*;
(
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         bcd_valid,
    input  wire  bcd_word_t bcd_data,
    input  wire         ovf,
    input  wire         enable,
    input  wire         blank_lz,
    input  wire  dp_pos_t   dp_pos,
    input  wire  scan_div_t scan_div,
    output seg_t        seg,
    output dig_sel_t    dig_sel
);

    localparam int IDX_W = $clog2(`DISP_DIGITS);

    bcd_word_t         bcd_hold;
    logic              ovf_hold;
    logic              have_result;
    scan_div_t         div_cnt;
    logic              scan_step;
    logic [IDX_W-1:0]  dig_idx;
    bcd_digit_t        cur_digit;
    logic              upper_zero;
    logic              blank_digit;
    seg_t              seg_nxt;

    // latest result, display stays dark until the first one
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bcd_hold    <= '0;
            ovf_hold    <= 1'b0;
            have_result <= 1'b0;
        end else if (bcd_valid) begin
            bcd_hold    <= bcd_data;
            ovf_hold    <= ovf;
            have_result <= 1'b1;
        end
    end

    //**************************************************************************
    // scan timing
    //**************************************************************************

    // >= so a smaller divider written mid-count still wraps
    assign scan_step = (div_cnt >= scan_div);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            div_cnt <= '0;
            dig_idx <= '0;
        end else begin
            div_cnt <= scan_step ? '0 : div_cnt + 1'b1;
            if (scan_step)
                dig_idx <= (dig_idx == IDX_W'(`DISP_DIGITS-1)) ? '0 : dig_idx + 1'b1;
        end
    end

    //**************************************************************************
    // digit decode
    //**************************************************************************

    always_comb begin
        cur_digit = bcd_hold[4*dig_idx +: 4];
        // any non-zero digit above the current one
        upper_zero = 1'b1;
        for (int i = 0; i < `DISP_DIGITS; i++) begin
            if ((i > dig_idx) && (bcd_hold[4*i +: 4] != 4'd0))
                upper_zero = 1'b0;
        end
        // digit 0 always shows
        blank_digit = blank_lz && !ovf_hold && (dig_idx != '0) &&
                      (cur_digit == 4'd0) && upper_zero;
        if (ovf_hold)
            seg_nxt = 8'hbf;    // dash, g only
        else if (blank_digit)
            seg_nxt = 8'hff;
        else begin
            case (cur_digit)
                4'd0:    seg_nxt = 8'hc0;
                4'd1:    seg_nxt = 8'hf9;
                4'd2:    seg_nxt = 8'ha4;
                4'd3:    seg_nxt = 8'hb0;
                4'd4:    seg_nxt = 8'h99;
                4'd5:    seg_nxt = 8'h92;
                4'd6:    seg_nxt = 8'h82;
                4'd7:    seg_nxt = 8'hf8;
                4'd8:    seg_nxt = 8'h80;
                4'd9:    seg_nxt = 8'h90;
                default: seg_nxt = 8'hff;
            endcase
        end
        // point applies on dash and blank digits too
        if (dig_idx == dp_pos)
            seg_nxt[7] = 1'b0;
    end

    // seg and dig_sel update together
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            seg     <= '1;
            dig_sel <= '1;
        end else if (scan_step) begin
            if (enable && have_result) begin
                seg     <= seg_nxt;
                dig_sel <= ~(dig_sel_t'(1) << dig_idx);
            end else begin
                seg     <= '1;
                dig_sel <= '1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/num_display_top.sv
// credit-based value input only; the display side always takes the latest result
`timescale 1ns/10ps
`default_nettype none

`include "disp_cfg.svh"

module num_display_top
    import disp_pkg::*;
(
    input  wire         sys_clk,
    input  wire         sys_rst_n,
    input  wire         value_valid,
    input  wire  bin_value_t value,
    input  wire         cfg_wr,
    input  wire  cfg_addr_t cfg_addr,
    input  wire  cfg_data_t cfg_wdata,
    output logic        credit_return,
    output logic        bcd_valid,
    output bcd_word_t   bcd_data,
    output logic        ovf,
    output cfg_data_t   cfg_rdata,
    output seg_t        seg,
    output dig_sel_t    dig_sel
);

    // register fields into the scanner
    logic       enable;
    logic       blank_lz;
    dp_pos_t    dp_pos;
    scan_div_t  scan_div;

    // binary to BCD with receive buffer
    bin_to_bcd_conv conv_i (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .value_valid   (value_valid),
        .value         (value),
        .credit_return (credit_return),
        .bcd_valid     (bcd_valid),
        .bcd_data      (bcd_data),
        .ovf           (ovf)
    );

    // software settings
    disp_cfg_regs regs_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .enable    (enable),
        .blank_lz  (blank_lz),
        .dp_pos    (dp_pos),
        .scan_div  (scan_div)
    );

    // six-digit multiplexed output
    seg_scan scan_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .bcd_valid (bcd_valid),
        .bcd_data  (bcd_data),
        .ovf       (ovf),
        .enable    (enable),
        .blank_lz  (blank_lz),
        .dp_pos    (dp_pos),
        .scan_div  (scan_div),
        .seg       (seg),
        .dig_sel   (dig_sel)
    );

endmodule

`default_nettype wire

//--- sim/num_display_tb.sv
// checks on rising edges with scan_div 3 for segment runs; stops at the first error
`timescale 1ns/10ps
`default_nettype none

`include "disp_cfg.svh"

module num_display_tb
    import disp_pkg::*;
();

    localparam dig_sel_t ALL_OFF      = '1;
    localparam int       CREDIT_LIMIT = 100;
    localparam int       RESULT_LIMIT = 200;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        value_valid;
    bin_value_t  value;
    logic        cfg_wr;
    cfg_addr_t   cfg_addr;
    cfg_data_t   cfg_wdata;
    logic        credit_return;
    logic        bcd_valid;
    bcd_word_t   bcd_data;
    logic        ovf;
    cfg_data_t   cfg_rdata;
    seg_t        seg;
    dig_sel_t    dig_sel;

    // producer side and scoreboard
    integer      seed;
    int          sent_cnt = 0;
    int          seen_cnt = 0;
    int          ret_cnt = 0;
    int          rx_cnt = 0;
    int unsigned exp_q [$];
    // what the display should be showing now
    bcd_word_t   shown_word = '0;
    logic        shown_ovf = 1'b0;
    logic        cur_blank = 1'b0;
    int          cur_dp = 7;
    logic        scan_chk = 1'b0;
    dig_sel_t    prev_sel = '1;
    dig_sel_t    visited = '0;
    // blanking and dp runs
    int unsigned run_vals [4] = '{0, 120, 7005, 40300};
    int          run_dp [4] = '{7, 2, 0, 5};

    num_display_top dut_i (.*);

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    //**************************************************************************
    // reference model
    //**************************************************************************

    // low six decimal digits by division, ovf from range
    function automatic logic [24:0] ref_bcd(input int unsigned v);
        logic [23:0] digits;
        int unsigned rest;
        digits = '0;
        rest   = v;
        for (int i = 0; i < `DISP_DIGITS; i++) begin
            digits[4*i +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return {(v >= 1000000), digits};
    endfunction

    // lit segments g..a, inverted for common anode
    function automatic logic [7:0] ref_seg(input logic [23:0] word, input logic ovf_f,
                                           input int idx, input logic blank, input int dp);
        logic [6:0] lit;
        logic [7:0] s;
        if (ovf_f)
            lit = 7'h40;
        else if (blank && (idx != 0) && ((word >> (4*idx)) == 0))
            lit = 7'h00;
        else begin
            case (word[4*idx +: 4])
                4'd0:    lit = 7'h3f;
                4'd1:    lit = 7'h06;
                4'd2:    lit = 7'h5b;
                4'd3:    lit = 7'h4f;
                4'd4:    lit = 7'h66;
                4'd5:    lit = 7'h6d;
                4'd6:    lit = 7'h7d;
                4'd7:    lit = 7'h07;
                4'd8:    lit = 7'h7f;
                4'd9:    lit = 7'h6f;
                default: lit = 7'h00;
            endcase
        end
        s = ~{1'b0, lit};
        if (idx == dp)
            s[7] = 1'b0;
        return s;
    endfunction

    function automatic int digit_index(input dig_sel_t sel);
        int idx;
        idx = 0;
        for (int i = 0; i < `DISP_DIGITS; i++)
            if (!sel[i])
                idx = i;
        return idx;
    endfunction

    function automatic int credits_left();
        return `DISP_CREDITS - (sent_cnt - ret_cnt);
    endfunction

    //**************************************************************************
    // reporting
    //**************************************************************************

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
                     $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    //**************************************************************************
    // stimulus tasks
    //**************************************************************************

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(posedge sys_clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge sys_clk);
        cfg_wr <= 1'b0;
    endtask

    // rdata is combinational, sample one edge after the address
    task automatic read_reg(input cfg_addr_t addr, input cfg_data_t exp, input string name);
        @(posedge sys_clk);
        cfg_addr <= addr;
        @(posedge sys_clk);
        check_val(name, cfg_rdata, exp);
    endtask

    // holds valid low until a credit is free
    task automatic send_value(input int unsigned v);
        int waited;
        waited = 0;
        @(posedge sys_clk);
        value_valid <= 1'b0;
        while (credits_left() == 0) begin
            waited++;
            if (waited > CREDIT_LIMIT)
                abort_run("no credit came back while the producer waited");
            @(posedge sys_clk);
        end
        value_valid <= 1'b1;
        value       <= bin_value_t'(v);
        exp_q.push_back(v);
        sent_cnt++;
    endtask

    task automatic stop_sending();
        @(posedge sys_clk);
        value_valid <= 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (rx_cnt != sent_cnt) begin
            waited++;
            if (waited > RESULT_LIMIT)
                abort_run("bcd_valid did not arrive for every value sent");
            @(posedge sys_clk);
        end
    endtask

    // one value through the converter, credits back to full
    task automatic show_value(input int unsigned v);
        send_value(v);
        stop_sending();
        wait_results();
        check_val("credits", credits_left(), `DISP_CREDITS);
    endtask

    // two settle cycles so the latched result reaches seg
    task automatic observe_scan();
        repeat (2) @(posedge sys_clk);
        visited  = '0;
        scan_chk = 1'b1;
        repeat (8 * `DISP_DIGITS) @(posedge sys_clk);
        scan_chk = 1'b0;
        check_val("digits scanned", visited, ALL_OFF);
    endtask

    task automatic wait_dark(input int limit);
        int waited;
        waited = 0;
        while (dig_sel !== ALL_OFF) begin
            waited++;
            if (waited > limit)
                abort_run("dig_sel still lit after enable was cleared");
            @(posedge sys_clk);
        end
    endtask

    //**************************************************************************
    // monitors
    //**************************************************************************

    // a credit may only come back for a value already received
    always @(posedge sys_clk) begin : credit_track
        if (sys_rst_n) begin
            if (value_valid)
                seen_cnt = seen_cnt + 1;
            if (credit_return) begin
                if (ret_cnt >= seen_cnt)
                    abort_run("credit_return with no value in the buffer");
                else
                    ret_cnt <= ret_cnt + 1;
            end
        end
    end

    // results in send order
    always @(posedge sys_clk) begin : result_check
        int unsigned v;
        logic [24:0] exp;
        if (sys_rst_n && bcd_valid) begin
            if (exp_q.size() == 0)
                abort_run("bcd_valid with no value outstanding");
            else begin
                v   = exp_q.pop_front();
                exp = ref_bcd(v);
                check_val("bcd_data", bcd_data, exp[23:0]);
                check_val("ovf", ovf, exp[24]);
                shown_word = exp[23:0];
                shown_ovf  = exp[24];
                rx_cnt++;
            end
        end
    end

    // dark before the first result, then seg on each digit change
    always @(posedge sys_clk) begin : scan_monitor
        int idx;
        if (sys_rst_n) begin
            if (rx_cnt == 0)
                check_val("dig_sel", dig_sel, ALL_OFF);
            else if (scan_chk && (dig_sel !== prev_sel) && (dig_sel !== ALL_OFF)) begin
                check_val("dig_sel lit count", $countones(~dig_sel), 1);
                idx = digit_index(dig_sel);
                visited[idx] = 1'b1;
                check_val("seg", seg, ref_seg(shown_word, shown_ovf, idx, cur_blank, cur_dp));
            end
            prev_sel = dig_sel;
        end
    end

    //**************************************************************************
    // test sequence
    //**************************************************************************

    initial begin
        sys_rst_n   = 1'b0;
        value_valid = 1'b0;
        value       = '0;
        cfg_wr      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        seed        = 32'h2cfc_5bae;
        repeat (2) @(posedge sys_clk);
        sys_rst_n <= 1'b1;

        // register defaults
        read_reg(2'd0, 16'h0001, "ctrl");
        read_reg(2'd1, 16'd7, "dp_pos");
        read_reg(2'd2, 16'd999, "scan_div");
        read_reg(2'd3, 16'h0000, "reserved");

        // in range, directed then random
        show_value(0);
        show_value(9);
        show_value(10);
        show_value(99999);
        show_value(999999);
        repeat (20) show_value($unsigned($random(seed)) % 1000000);

        // faster scan, dp writes truncated to three bits
        write_reg(2'd2, 16'd3);
        read_reg(2'd2, 16'd3, "scan_div");
        write_reg(2'd1, 16'hfff2);
        read_reg(2'd1, 16'd2, "dp_pos");
        write_reg(2'd1, 16'hfff7);
        read_reg(2'd1, 16'd7, "dp_pos");

        // overflow shows dashes everywhere
        show_value(1000000);
        observe_scan();
        show_value(1048575);
        observe_scan();
        repeat (4) show_value(1000000 + ($unsigned($random(seed)) % 48576));

        // back to back at full credit
        repeat (12) send_value($unsigned($random(seed)) % 1048576);
        stop_sending();
        wait_results();
        check_val("credits", credits_left(), `DISP_CREDITS);

        // blanking and decimal point runs
        for (int run = 0; run < 4; run++) begin
            cur_blank = run[0];
            cur_dp    = run_dp[run];
            write_reg(2'd0, {14'd0, cur_blank, 1'b1});
            write_reg(2'd1, 16'(cur_dp));
            show_value(run_vals[run]);
            observe_scan();
        end

        // display off within scan_div+2 cycles, then stays off
        write_reg(2'd0, 16'h0000);
        wait_dark(3 + 2);
        repeat (20) begin
            @(posedge sys_clk);
            check_val("dig_sel", dig_sel, ALL_OFF);
        end

        check_val("pending values", exp_q.size(), 0);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- num_display_top.f
+incdir+include
verilog/disp_pkg.sv
verilog/bin_to_bcd_conv.sv
verilog/disp_cfg_regs.sv
verilog/seg_scan.sv
verilog/num_display_top.sv
sim/num_display_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= num_display_tb
FILELIST  ?= num_display_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
